/* hw/recomb_consts.svh */
`ifndef RECOMB_CONSTS_SVH
`define RECOMB_CONSTS_SVH

// slot layout in the cell buffer
`define RECOMB_SLOTS 16
`define RECOMB_SLOT_BITS 4
`define RECOMB_SLOT_WORDS 32
`define RECOMB_HALF 16 // part 1 starts here
`define RECOMB_ADDR_BITS 9

// field widths
`define RECOMB_DATA_BITS 32
`define RECOMB_ID_BITS 16
`define RECOMB_STAMP_BITS 15

`define RECOMB_META_DEPTH 8
`define RECOMB_CELL_DEPTH 64

// age limit in ticks and default tick divisor
`define RECOMB_AGE_LIMIT 4
`define RECOMB_TICK_CYCLES 125000000

`endif

/* hw/recomb_pkg.sv */
`default_nettype none
`include "recomb_consts.svh"

package recomb_pkg;

	typedef logic [`RECOMB_SLOT_BITS-1:0] slot_num_t;

	typedef struct packed {
		logic last; // final cell of a part
		logic [`RECOMB_DATA_BITS-1:0] data;
	} cell_t;

	typedef struct packed {
		logic part; // 0 or 1
		logic [`RECOMB_ID_BITS-1:0] id;
		logic [31:0] info;
	} meta_in_t;

	typedef struct packed {
		slot_num_t slot;
		logic [31:0] info;
	} meta_out_t;

	// controller to slot table
	typedef struct packed {
		logic record;
		logic clear;
		slot_num_t slot;
		logic [`RECOMB_ID_BITS-1:0] id;
	} slot_cmd_t;

	typedef struct packed {
		logic valid;
		logic [`RECOMB_STAMP_BITS-1:0] stamp;
		logic [`RECOMB_ID_BITS-1:0] id;
	} slot_entry_t;

endpackage

`default_nettype wire

/* hw/recomb_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module recomb_fifo #(
	parameter type T = logic,
	parameter int depth = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire T wr_data,
	input wire logic wr_valid,
	output T rd_data,
	output logic empty,
	input wire logic pop,
	output logic credit
);
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = aw + 1;

	T mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
		return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == cw'(depth));
	assign empty = (count == '0);
	assign do_wr = wr_valid && !full; // beat sent without credit is lost
	assign do_rd = pop && !empty;
	assign rd_data = mem[rd_ptr]; // head shows before the pop

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + cw'(do_wr) - cw'(do_rd);
			credit <= do_rd; // one credit back per popped word
		end
	end

	// sender overran its credits
	assert property (@(posedge clk) disable iff (!reset) wr_valid |-> !full)
		else $error("recomb_fifo: write into full fifo, beat dropped");

	assert property (@(posedge clk) disable iff (!reset) pop |-> !empty)
		else $error("recomb_fifo: pop while empty");

endmodule

`default_nettype wire

/* hw/slot_table.sv */
`timescale 1ns/1ps
`default_nettype none
`include "recomb_consts.svh"

module slot_table #(
	parameter int unsigned tick_cycles = `RECOMB_TICK_CYCLES
) (
	input wire logic clk,
	input wire logic reset,
	input wire recomb_pkg::slot_cmd_t cmd,
	input wire logic [`RECOMB_ID_BITS-1:0] lookup_id,
	output logic hit,
	output recomb_pkg::slot_num_t hit_slot,
	output recomb_pkg::slot_num_t recycle_slot,
	output logic recycle_valid
);
	import recomb_pkg::*;

	localparam int stamp_bits = `RECOMB_STAMP_BITS;

	slot_entry_t entries [`RECOMB_SLOTS];
	logic [31:0] div_cnt;
	logic [stamp_bits-1:0] stamp;
	slot_num_t scan_idx;
	slot_entry_t scan_entry;
	logic [stamp_bits-1:0] age;
	logic expired;
	logic cmd_touch;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			div_cnt <= '0;
			stamp <= '0;
		end else if (div_cnt == 32'(tick_cycles - 1)) begin
			div_cnt <= '0;
			stamp <= stamp + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign scan_entry = entries[scan_idx];
	assign age = stamp - scan_entry.stamp; // wraps with the stamp
	assign expired = scan_entry.valid && (age > stamp_bits'(`RECOMB_AGE_LIMIT));
	// leave the entry alone while the controller writes it
	assign cmd_touch = (cmd.record || cmd.clear) && (cmd.slot == scan_idx);

	// lowest matching slot wins
	always_comb begin
		hit = 1'b0;
		hit_slot = '0;
		for (int i = `RECOMB_SLOTS - 1; i >= 0; i--) begin
			if (entries[i].valid && entries[i].id == lookup_id) begin
				hit = 1'b1;
				hit_slot = slot_num_t'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `RECOMB_SLOTS; i++)
				entries[i] <= '0;
			scan_idx <= '0;
			recycle_valid <= 1'b0;
		end else begin
			scan_idx <= scan_idx + 1'b1; // round robin
			recycle_valid <= 1'b0;
			if (cmd.record)
				entries[cmd.slot] <= '{valid: 1'b1, stamp: stamp, id: cmd.id};
			else if (cmd.clear)
				entries[cmd.slot].valid <= 1'b0;
			if (expired && !cmd_touch) begin
				entries[scan_idx].valid <= 1'b0;
				recycle_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (expired && !cmd_touch)
			recycle_slot <= scan_idx;
	end

	assert property (@(posedge clk) disable iff (!reset) !(cmd.record && cmd.clear))
		else $error("slot_table: record and clear in one cycle");

endmodule

`default_nettype wire

/* hw/recomb_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "recomb_consts.svh"

module recomb_ctrl (
	input wire logic clk,
	input wire logic reset,
	input wire recomb_pkg::meta_in_t meta_head,
	input wire logic meta_empty,
	output logic meta_pop,
	input wire recomb_pkg::cell_t cell_head,
	input wire logic cell_empty,
	output logic cell_pop,
	input wire recomb_pkg::slot_num_t free_head,
	input wire logic free_empty,
	output logic free_pop,
	output recomb_pkg::slot_cmd_t cmd,
	output logic [`RECOMB_ID_BITS-1:0] lookup_id,
	input wire logic hit,
	input wire recomb_pkg::slot_num_t hit_slot,
	output logic buf_wr_en,
	output logic [`RECOMB_ADDR_BITS-1:0] buf_wr_addr,
	output recomb_pkg::cell_t buf_wr_data,
	output recomb_pkg::meta_out_t meta_out,
	output logic meta_out_valid
);
	import recomb_pkg::*;

	localparam int addr_bits = `RECOMB_ADDR_BITS;
	localparam int off_bits = `RECOMB_ADDR_BITS - `RECOMB_SLOT_BITS;

	typedef enum logic [1:0] {idle_s, parse_s, copy_s, discard_s} state_t;

	state_t state;
	meta_in_t meta_q;
	slot_num_t slot_q;
	logic [addr_bits-1:0] wr_addr;
	logic matched;
	logic take_cell;

	// part 0 waits for a free slot at the head
	assign meta_pop = (state == idle_s) && !meta_empty && (meta_head.part || !free_empty);
	assign free_pop = (state == parse_s) && !meta_q.part;
	assign take_cell = (state == copy_s || state == discard_s) && !cell_empty;
	assign cell_pop = take_cell;
	assign lookup_id = meta_q.id;

	always_comb begin
		cmd.record = (state == parse_s) && !meta_q.part;
		cmd.clear = (state == parse_s) && meta_q.part && hit; // entry freed on match
		cmd.slot = meta_q.part ? hit_slot : free_head;
		cmd.id = meta_q.id;
	end

	assign buf_wr_en = (state == copy_s) && !cell_empty;
	assign buf_wr_addr = wr_addr;
	assign buf_wr_data = cell_head; // last flag stored with the cell

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= idle_s;
			matched <= 1'b0;
			meta_out_valid <= 1'b0;
		end else begin
			meta_out_valid <= 1'b0;
			case (state)
				idle_s: begin
					if (meta_pop)
						state <= parse_s;
				end
				parse_s: begin
					matched <= meta_q.part && hit;
					if (!meta_q.part || hit)
						state <= copy_s;
					else
						state <= discard_s; // unknown id
				end
				copy_s: begin
					if (take_cell && cell_head.last) begin
						state <= idle_s;
						meta_out_valid <= matched;
					end
				end
				discard_s: begin
					if (take_cell && cell_head.last)
						state <= idle_s;
				end
				default: state <= idle_s;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (meta_pop)
			meta_q <= meta_head;
		if (state == parse_s) begin
			slot_q <= cmd.slot;
			if (meta_q.part)
				wr_addr <= {hit_slot, off_bits'(`RECOMB_HALF)};
			else
				wr_addr <= {free_head, {off_bits{1'b0}}};
		end else if (buf_wr_en) begin
			wr_addr <= wr_addr + 1'b1;
		end
		if (buf_wr_en && cell_head.last) begin
			meta_out.slot <= slot_q;
			meta_out.info <= meta_q.info;
		end
	end

	// a part longer than its half would run into the next slot
	assert property (@(posedge clk) disable iff (!reset)
		buf_wr_en |-> buf_wr_addr[addr_bits-1:off_bits] == slot_q)
		else $error("recomb_ctrl: buffer write outside slot %0d", slot_q);

endmodule

`default_nettype wire

/* hw/cell_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "recomb_consts.svh"

module cell_buffer (
	input wire logic clk,
	input wire logic wr_en,
	input wire logic [`RECOMB_ADDR_BITS-1:0] wr_addr,
	input wire recomb_pkg::cell_t wr_data,
	input wire logic rd_en,
	input wire logic [`RECOMB_ADDR_BITS-1:0] rd_addr,
	output recomb_pkg::cell_t rd_data
);
	import recomb_pkg::*;

	localparam int words = `RECOMB_SLOTS * `RECOMB_SLOT_WORDS;

	cell_t mem [words];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr]; // valid the cycle after rd_en
	end

endmodule

`default_nettype wire

/* hw/pkt_recomb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "recomb_consts.svh"

module pkt_recomb #(
	parameter int unsigned tick_cycles = `RECOMB_TICK_CYCLES
) (
	input wire logic clk,
	input wire logic reset,
	input wire recomb_pkg::meta_in_t meta_in,
	input wire logic meta_in_valid,
	output logic meta_credit,
	input wire recomb_pkg::cell_t cell_in,
	input wire logic cell_in_valid,
	output logic cell_credit,
	input wire recomb_pkg::slot_num_t free_slot,
	input wire logic free_slot_valid,
	output recomb_pkg::meta_out_t meta_out,
	output logic meta_out_valid,
	output recomb_pkg::slot_num_t recycle_slot,
	output logic recycle_valid,
	input wire logic rd_en,
	input wire logic [`RECOMB_ADDR_BITS-1:0] rd_addr,
	output recomb_pkg::cell_t rd_data
);
	import recomb_pkg::*;

	meta_in_t meta_head;
	cell_t cell_head;
	cell_t buf_wr_data;
	slot_num_t free_head;
	slot_num_t hit_slot;
	slot_cmd_t cmd;
	logic meta_empty, meta_pop;
	logic cell_empty, cell_pop;
	logic free_empty, free_pop;
	logic [`RECOMB_ID_BITS-1:0] lookup_id;
	logic hit;
	logic buf_wr_en;
	logic [`RECOMB_ADDR_BITS-1:0] buf_wr_addr;

	recomb_fifo #(.T(meta_in_t), .depth(`RECOMB_META_DEPTH)) meta_fifo (
		.clk, .reset, .wr_data(meta_in), .wr_valid(meta_in_valid),
		.rd_data(meta_head), .empty(meta_empty), .pop(meta_pop), .credit(meta_credit));

	recomb_fifo #(.T(cell_t), .depth(`RECOMB_CELL_DEPTH)) cell_fifo (
		.clk, .reset, .wr_data(cell_in), .wr_valid(cell_in_valid),
		.rd_data(cell_head), .empty(cell_empty), .pop(cell_pop), .credit(cell_credit));

	// only 16 slots exist, so no credit loop here
	recomb_fifo #(.T(slot_num_t), .depth(`RECOMB_SLOTS)) slot_fifo (
		.clk, .reset, .wr_data(free_slot), .wr_valid(free_slot_valid),
		.rd_data(free_head), .empty(free_empty), .pop(free_pop), .credit());

	recomb_ctrl u_ctrl (
		.clk, .reset, .meta_head, .meta_empty, .meta_pop, .cell_head, .cell_empty, .cell_pop,
		.free_head, .free_empty, .free_pop, .cmd, .lookup_id, .hit, .hit_slot,
		.buf_wr_en, .buf_wr_addr, .buf_wr_data, .meta_out, .meta_out_valid);

	slot_table #(.tick_cycles(tick_cycles)) u_table (
		.clk, .reset, .cmd, .lookup_id, .hit, .hit_slot, .recycle_slot, .recycle_valid);

	cell_buffer u_buffer (
		.clk, .wr_en(buf_wr_en), .wr_addr(buf_wr_addr), .wr_data(buf_wr_data),
		.rd_en, .rd_addr, .rd_data);

endmodule

`default_nettype wire

/* verif/tb_pkt_recomb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "recomb_consts.svh"

module tb_pkt_recomb;
	import recomb_pkg::*;

	localparam int tick = 4; // cycles per stamp tick
	localparam int slot_words = `RECOMB_SLOT_WORDS;

	logic clk = 1'b0;
	logic reset;
	meta_in_t meta_in;
	logic meta_in_valid;
	logic meta_credit;
	cell_t cell_in;
	logic cell_in_valid;
	logic cell_credit;
	slot_num_t free_slot;
	logic free_slot_valid;
	meta_out_t meta_out;
	logic meta_out_valid;
	slot_num_t recycle_slot;
	logic recycle_valid;
	logic rd_en;
	logic [`RECOMB_ADDR_BITS-1:0] rd_addr;
	cell_t rd_data;

	int seed = 62;
	int errors = 0;
	int tests = 0;
	int meta_sent = 0;
	int meta_back = 0;
	int cell_sent = 0;
	int cell_back = 0;
	meta_out_t out_q[$];
	slot_num_t recycle_q[$];
	cell_t model [`RECOMB_SLOTS * `RECOMB_SLOT_WORDS]; // expected buffer contents

	pkt_recomb #(.tick_cycles(tick)) u_pkt_recomb (.*);

	always #20 clk = ~clk;

	// pulses from registered outputs
	always @(posedge clk) begin
		if (meta_credit)
			meta_back++;
		if (cell_credit)
			cell_back++;
		if (meta_out_valid)
			out_q.push_back(meta_out);
		if (recycle_valid)
			recycle_q.push_back(recycle_slot);
	end

	task automatic check_meta(input string name, input meta_out_t got, input meta_out_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cell(input string name, input cell_t got, input cell_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_slot(input string name, input slot_num_t got, input slot_num_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("** Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report(input string name, input int errors_before);
		tests++;
		$display("%s: %s", name, (errors == errors_before) ? "pass" : "fail");
	endtask

	task automatic send_meta(input logic pt, input logic [15:0] id, input logic [31:0] info);
		int n = 0;
		while (meta_sent - meta_back >= `RECOMB_META_DEPTH && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (meta_sent - meta_back >= `RECOMB_META_DEPTH) begin
			$display("metadata sender got no credit back at %0t ns", $time);
			errors++;
			return;
		end
		@(negedge clk);
		meta_in.part = pt;
		meta_in.id = id;
		meta_in.info = info;
		meta_in_valid = 1'b1;
		meta_sent++;
		@(negedge clk);
		meta_in_valid = 1'b0;
	endtask

	task automatic send_cell(input cell_t c);
		int n = 0;
		while (cell_sent - cell_back >= `RECOMB_CELL_DEPTH && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (cell_sent - cell_back >= `RECOMB_CELL_DEPTH) begin
			$display("cell sender got no credit back at %0t ns", $time);
			errors++;
			return;
		end
		@(negedge clk);
		cell_in = c;
		cell_in_valid = 1'b1;
		cell_sent++;
		@(negedge clk);
		cell_in_valid = 1'b0;
	endtask

	// base < 0 means the part is expected to be dropped
	task automatic send_part(input logic pt, input logic [15:0] id, input logic [31:0] info,
			input int ncells, input int base);
		cell_t c;
		send_meta(pt, id, info);
		for (int k = 0; k < ncells; k++) begin
			c.data = $random(seed);
			c.last = (k == ncells - 1);
			if (base >= 0)
				model[base + k] = c;
			send_cell(c);
		end
	endtask

	task automatic push_slot(input slot_num_t s);
		@(negedge clk);
		free_slot = s;
		free_slot_valid = 1'b1;
		@(negedge clk);
		free_slot_valid = 1'b0;
	endtask

	task automatic wait_meta_out(input int limit, input bit want);
		int n = 0;
		while (out_q.size() == 0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (want && out_q.size() == 0) begin
			$display("no meta_out_valid within %0d cycles", limit);
			errors++;
		end else if (!want && out_q.size() != 0) begin
			$display("meta_out_valid pulsed for a part 1 that had no match");
			errors++;
		end
	endtask

	task automatic wait_recycle(input int limit);
		int n = 0;
		while (recycle_q.size() == 0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (recycle_q.size() == 0) begin
			$display("no recycle_valid within %0d cycles", limit);
			errors++;
		end
	endtask

	// every beat sent has had its credit returned
	task automatic wait_drain(input int limit);
		int n = 0;
		while ((meta_back != meta_sent || cell_back != cell_sent) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (meta_back != meta_sent || cell_back != cell_sent) begin
			$display("credits still outstanding after %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic check_buffer(input int base, input int ncells);
		for (int k = 0; k < ncells; k++) begin
			@(negedge clk);
			rd_en = 1'b1;
			rd_addr = `RECOMB_ADDR_BITS'(base + k);
			@(negedge clk);
			rd_en = 1'b0;
			check_cell($sformatf("rd_data[%0d]", base + k), rd_data, model[base + k]);
		end
	endtask

	task automatic test_reset_idle();
		int e0 = errors;
		repeat (8) @(negedge clk);
		check_count("meta_out_valid pulses", out_q.size(), 0);
		check_count("recycle_valid pulses", recycle_q.size(), 0);
		check_count("meta_credit pulses", meta_back, 0);
		check_count("cell_credit pulses", cell_back, 0);
		report("reset_idle", e0);
	endtask

	task automatic test_recombine();
		int e0 = errors;
		logic [15:0] id;
		meta_out_t exp_out;
		id = $random(seed);
		exp_out.slot = 4'd5;
		exp_out.info = $random(seed);
		push_slot(4'd5);
		send_part(1'b0, id, $random(seed), 3, 5 * slot_words);
		send_part(1'b1, id, exp_out.info, 4, 5 * slot_words + `RECOMB_HALF);
		wait_meta_out(100, 1'b1);
		if (out_q.size() != 0)
			check_meta("meta_out", out_q.pop_front(), exp_out);
		wait_drain(200);
		check_buffer(5 * slot_words, 3);
		check_buffer(5 * slot_words + `RECOMB_HALF, 4);
		report("recombine", e0);
	endtask

	task automatic test_unmatched();
		int e0 = errors;
		send_part(1'b1, $random(seed), $random(seed), 2, -1);
		wait_meta_out(60, 1'b0);
		wait_drain(200);
		check_count("cell credits returned", cell_back, cell_sent);
		report("unmatched", e0);
	endtask

	task automatic test_aging();
		int e0 = errors;
		logic [15:0] id;
		id = $random(seed);
		// slot 5 was freed by its match, so nothing has aged out yet
		check_count("recycle_valid pulses before aging", recycle_q.size(), 0);
		recycle_q.delete();
		push_slot(4'd9);
		send_part(1'b0, id, $random(seed), 2, 9 * slot_words);
		wait_recycle((`RECOMB_AGE_LIMIT + 2) * tick + 16);
		if (recycle_q.size() != 0)
			check_slot("recycle_slot", recycle_q.pop_front(), 4'd9);
		send_part(1'b1, id, $random(seed), 2, -1); // entry gone, so dropped
		wait_meta_out(60, 1'b0);
		wait_drain(200);
		report("aging", e0);
	endtask

	task automatic test_backpressure();
		int e0 = errors;
		int c0 = cell_back;
		send_part(1'b0, $random(seed), $random(seed), 3, 3 * slot_words);
		repeat (30) @(negedge clk); // no free slot yet
		check_count("cell credits without a free slot", cell_back - c0, 0);
		push_slot(4'd3);
		wait_drain(200);
		check_buffer(3 * slot_words, 3);
		report("backpressure", e0);
	endtask

	initial begin
		reset = 1'b0;
		meta_in = '0;
		meta_in_valid = 1'b0;
		cell_in = '0;
		cell_in_valid = 1'b0;
		free_slot = '0;
		free_slot_valid = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		repeat (2) @(negedge clk);
		reset = 1'b1;
		test_reset_idle();
		test_recombine();
		test_unmatched();
		test_aging();
		test_backpressure();
		check_count("meta credits over the run", meta_back, meta_sent);
		check_count("cell credits over the run", cell_back, cell_sent);
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/recomb_pkg.sv
hw/recomb_fifo.sv
hw/slot_table.sv
hw/recomb_ctrl.sv
hw/cell_buffer.sv
hw/pkt_recomb.sv
verif/tb_pkt_recomb.sv

/* Makefile */
# Verilator build and run for the packet recombiner

VERILATOR ?= verilator
TOP       ?= tb_pkt_recomb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) hw/recomb_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
